// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_modexp
FILELIST  = sim.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: exp_ctrl.sv
/* left-to-right square-and-multiply controller
   schedules Montgomery products, scans e and streams the result */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module exp_ctrl import mont_pkg::*, exp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     start_compute,
	input  logic     get_result,
	input  logic     load_done,
	input  operand_t m_val,
	input  operand_t e_val,
	input  operand_t r_val,
	input  operand_t t_val,
	input  operand_t mm_result,
	input  logic     mm_done,
	output operand_t operand_a,
	output operand_t operand_b,
	output logic     mm_start,
	output word_t    res_word,
	output logic     res_valid,
	output logic     done
);

	exp_state_e state;
	operand_t m_bar;	// m in Montgomery form
	operand_t c_bar;	// running result, plain integer after FROM_MONT
	bit_idx_t bit_idx;	// exponent bit under test
	logic [`WORD_IDX_WIDTH-1:0] out_idx;
	logic bit_set;
	logic bit_last;

	assign bit_set = e_val[bit_idx];
	assign bit_last = (bit_idx == '0);
	assign done = (state == COMPLETE);
	assign res_valid = (state == OUTPUT);
	assign res_word = res_valid ? c_bar[out_idx*`WORD_WIDTH +: `WORD_WIDTH] : '0;

	// product operands, stable for the whole state
	always_comb begin
		operand_a = c_bar;
		operand_b = c_bar;
		case (state)
			TO_MONT: begin
				operand_a = m_val;
				operand_b = t_val;	// m * r^2 * r^-1 = m * r
			end
			MULTIPLY: operand_b = m_bar;
			FROM_MONT: operand_a = `ONE_OPERAND;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			mm_start <= 1'b0;
			bit_idx <= '0;
			out_idx <= '0;
		end else begin
			mm_start <= 1'b0;
			case (state)
				IDLE, TERMINAL: begin
					if (load_done)
						state <= LOAD;
				end
				LOAD, WAIT_COMPUTE: begin
					if (state == LOAD) begin
						bit_idx <= bit_idx_t'(`OPERAND_WIDTH - 1);	// scan from the top bit
						out_idx <= '0;
					end
					state <= WAIT_COMPUTE;
					if (start_compute) begin
						state <= TO_MONT;
						mm_start <= 1'b1;
					end
				end
				TO_MONT: begin
					if (mm_done)
						state <= FIND_TOP;
				end
				FIND_TOP: begin
					if (bit_last) begin
						state <= FROM_MONT;	// e = 1 or e = 0
						mm_start <= 1'b1;
					end else if (bit_set) begin
						state <= SQUARE;
						bit_idx <= bit_idx - 1'b1;
						mm_start <= 1'b1;
					end else begin
						bit_idx <= bit_idx - 1'b1;
					end
				end
				SQUARE: begin
					if (mm_done) begin
						mm_start <= 1'b1;
						if (bit_set) begin
							state <= MULTIPLY;
						end else if (bit_last) begin
							state <= FROM_MONT;
						end else begin
							bit_idx <= bit_idx - 1'b1;
						end
					end
				end
				MULTIPLY: begin
					if (mm_done) begin
						mm_start <= 1'b1;
						if (bit_last) begin
							state <= FROM_MONT;
						end else begin
							state <= SQUARE;
							bit_idx <= bit_idx - 1'b1;
						end
					end
				end
				FROM_MONT: begin
					if (mm_done)
						state <= COMPLETE;
				end
				COMPLETE: begin
					if (get_result) begin
						state <= OUTPUT;
						out_idx <= '0;
					end
				end
				OUTPUT: begin
					out_idx <= out_idx + 1'b1;
					if (int'(out_idx) == `NUM_WORDS - 1)
						state <= TERMINAL;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// c_bar starts as r (Montgomery one) and takes m_bar at the leading one of e
	always_ff @(posedge clk) begin
		if (mm_done) begin
			if (state == TO_MONT) begin
				m_bar <= mm_result;
				c_bar <= r_val;
			end else begin
				c_bar <= mm_result;
			end
		end else if (state == FIND_TOP && bit_set) begin
			c_bar <= m_bar;
		end
	end

endmodule

// File: exp_pkg.sv
/* exponentiation types
   full operands, exponent bit index and the controller states */
`include "modexp_consts.svh"

package exp_pkg;

	typedef logic [`OPERAND_WIDTH-1:0] operand_t;	// word 0 in the low bits
	typedef logic [`BIT_IDX_WIDTH-1:0] bit_idx_t;

	typedef enum logic [3:0] {
		IDLE,
		LOAD,
		WAIT_COMPUTE,
		TO_MONT,
		FIND_TOP,
		SQUARE,
		MULTIPLY,
		FROM_MONT,
		COMPLETE,
		OUTPUT,
		TERMINAL
	} exp_state_e;

endpackage

// File: modexp.sv
/* modular exponentiation engine, m^e mod n
   operand loader, exponent controller and Montgomery product unit */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module modexp import mont_pkg::*, exp_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  start_input,
	input  logic  start_compute,
	input  logic  get_result,
	input  word_t m_word,
	input  word_t e_word,
	input  word_t n_word,
	input  word_t r_word,
	input  word_t t_word,
	input  word_t n_prime0,
	output word_t res_word,
	output logic  res_valid,
	output logic  done
);

	operand_t m_val;
	operand_t e_val;
	operand_t n_val;
	operand_t r_val;
	operand_t t_val;
	word_t    n_prime0_val;
	logic     load_done;
	operand_t operand_a;
	operand_t operand_b;
	operand_t mm_result;
	logic     mm_start;
	logic     mm_done;

	operand_load u_operand_load (
		.clk         (clk),
		.reset       (reset),
		.start_input (start_input),
		.m_word      (m_word),
		.e_word      (e_word),
		.n_word      (n_word),
		.r_word      (r_word),
		.t_word      (t_word),
		.n_prime0    (n_prime0),
		.m_val       (m_val),
		.e_val       (e_val),
		.n_val       (n_val),
		.r_val       (r_val),
		.t_val       (t_val),
		.n_prime0_val(n_prime0_val),
		.load_done   (load_done)
	);

	exp_ctrl u_exp_ctrl (
		.clk          (clk),
		.reset        (reset),
		.start_compute(start_compute),
		.get_result   (get_result),
		.load_done    (load_done),
		.m_val        (m_val),
		.e_val        (e_val),
		.r_val        (r_val),
		.t_val        (t_val),
		.mm_result    (mm_result),
		.mm_done      (mm_done),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.mm_start     (mm_start),
		.res_word     (res_word),
		.res_valid    (res_valid),
		.done         (done)
	);

	mont_mult u_mont_mult (
		.clk         (clk),
		.reset       (reset),
		.mm_start    (mm_start),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.n_val       (n_val),
		.n_prime0_val(n_prime0_val),
		.mm_result   (mm_result),
		.mm_done     (mm_done)
	);

endmodule

// File: modexp_consts.svh
/* modexp sizing constants
   word width, operand length and the widths derived from them */
`ifndef MODEXP_CONSTS_SVH
`define MODEXP_CONSTS_SVH

`define WORD_WIDTH 16	// bits per arithmetic word
`define NUM_WORDS 4	// words per operand, 64-bit modulus

`define OPERAND_WIDTH (`WORD_WIDTH * `NUM_WORDS)

// index widths for word and exponent bit counters
`define WORD_IDX_WIDTH $clog2(`NUM_WORDS)
`define BIT_IDX_WIDTH $clog2(`OPERAND_WIDTH)

// plain integer one, the left operand of the from-Montgomery pass
`define ONE_OPERAND {{(`OPERAND_WIDTH - 1){1'b0}}, 1'b1}

`endif

// File: modexp_patterns.hex
// per test: m[0..3] e[0..3] n[0..3], then r[0..3] t[0..3] n_prime0 expected[0..3]
// 16-bit hex words, least significant word first
FFDF FFFF FFFF 1FFF  CDEF 89AB 4567 0123  FFFF FFFF FFFF 1FFF  // multi-word exponent
0008 0000 0000 0000  0040 0000 0000 0000  0001  FFFF FFFF FFFF 1EFF
DEF0 9ABC 5678 1234  0001 0000 0000 0000  0001 0000 0000 2000  // e = 1
FFF9 FFFF FFFF 1FFF  0040 0000 0000 0000  FFFF  DEF0 9ABC 5678 1234
4321 8765 CBA9 0FED  0000 0000 0000 0000  FFFF FFFF FFFF 1FFF  // e = 0
0008 0000 0000 0000  0040 0000 0000 0000  0001  0001 0000 0000 0000
0020 0000 0000 0000  FFFF FFFF FFFF FFFF  0001 0000 0000 2000  // e all ones
FFF9 FFFF FFFF 1FFF  0040 0000 0000 0000  FFFF  C001 FFFF FFFF 1FFF
FBFF 7FFF 0000 0000  FDB9 ACE0 2468 1357  FFFF 7FFF 0000 0000  // two-word modulus
0004 0000 0000 0000  0010 0000 0000 0000  0001  DFFF 7FFF 0000 0000
0001 FFF0 FFFF 1FFF  CDEF 89AB 4567 0123  0001 0000 0000 2000  // negative base
FFF9 FFFF FFFF 1FFF  0040 0000 0000 0000  FFFF  0000 0000 0200 0000

// File: mont_mult.sv
/* CIOS Montgomery product a*b*2^-OPERAND_WIDTH mod n
   word serial over one shared multiply-accumulate, result below 2n */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module mont_mult import mont_pkg::*, exp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     mm_start,
	input  operand_t operand_a,
	input  operand_t operand_b,
	input  operand_t n_val,
	input  word_t    n_prime0_val,
	output operand_t mm_result,
	output logic     mm_done
);

	word_t v [`NUM_WORDS+1:0];	// accumulator with two spare top words
	word_t carry;
	word_t q;	// quotient word of the current outer pass
	mont_step_e step;
	logic busy;
	logic phase;	// 0 issue, 1 store
	logic [`WORD_IDX_WIDTH-1:0] i;	// outer word of a
	logic [`WORD_IDX_WIDTH-1:0] j;	// inner word of b and n
	word_t mul_x;
	word_t mul_y;
	word_t mul_z;
	word_t mul_c_in;
	word_t mul_s;
	word_t mul_c;
	logic store;
	logic last_inner;
	logic last_outer;

	assign store = busy && phase;
	assign last_inner = (int'(j) == `NUM_WORDS - 1);
	assign last_outer = (int'(i) == `NUM_WORDS - 1);

	mul_add u_mul_add (
		.clk   (clk),
		.x     (mul_x),
		.y     (mul_y),
		.z     (mul_z),
		.last_c(mul_c_in),
		.s     (mul_s),
		.c     (mul_c)
	);

	// operands presented to the multiply-accumulate for the current step
	always_comb begin
		mul_x = '0;
		mul_y = '0;
		mul_z = '0;
		mul_c_in = '0;
		case (step)
			ACCUM: begin
				mul_x = operand_a[i*`WORD_WIDTH +: `WORD_WIDTH];
				mul_y = operand_b[j*`WORD_WIDTH +: `WORD_WIDTH];
				mul_z = v[j];
				mul_c_in = carry;
			end
			CARRY_TOP, FOLD_TOP: begin
				mul_z = v[`NUM_WORDS];
				mul_c_in = carry;
			end
			QUOTIENT: begin
				mul_x = v[0];
				mul_y = n_prime0_val;
			end
			REDUCE: begin
				mul_x = q;
				mul_y = n_val[j*`WORD_WIDTH +: `WORD_WIDTH];
				mul_z = v[j];
				mul_c_in = carry;	// zero on j == 0, cleared in CARRY_TOP
			end
			FOLD_CARRY: begin
				mul_z = v[`NUM_WORDS+1];
				mul_c_in = carry;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			phase <= 1'b0;
			step <= ACCUM;
			i <= '0;
			j <= '0;
			carry <= '0;
			mm_done <= 1'b0;
			for (int k = 0; k < `NUM_WORDS + 2; k++)
				v[k] <= '0;
		end else begin
			mm_done <= 1'b0;
			if (!busy) begin
				if (mm_start) begin
					busy <= 1'b1;
					step <= ACCUM;
				end
			end else if (step == FINISH) begin
				busy <= 1'b0;	// back to idle, accumulator clean for the next product
				step <= ACCUM;
				i <= '0;
				j <= '0;
				carry <= '0;
				for (int k = 0; k < `NUM_WORDS + 2; k++)
					v[k] <= '0;
			end else if (!phase) begin
				phase <= 1'b1;
			end else begin
				phase <= 1'b0;
				case (step)
					ACCUM: begin
						v[j] <= mul_s;
						carry <= mul_c;
						j <= j + 1'b1;
						if (last_inner) begin
							j <= '0;
							step <= CARRY_TOP;
						end
					end
					CARRY_TOP: begin
						v[`NUM_WORDS] <= mul_s;
						v[`NUM_WORDS+1] <= mul_c;
						carry <= '0;
						step <= QUOTIENT;
					end
					QUOTIENT: step <= REDUCE;
					REDUCE: begin
						if (j != '0)
							v[j - 1'b1] <= mul_s;	// word 0 drops out, it is zero
						carry <= mul_c;
						j <= j + 1'b1;
						if (last_inner) begin
							j <= '0;
							step <= FOLD_TOP;
						end
					end
					FOLD_TOP: begin
						v[`NUM_WORDS-1] <= mul_s;
						carry <= mul_c;
						step <= FOLD_CARRY;
					end
					FOLD_CARRY: begin
						v[`NUM_WORDS] <= mul_s;
						carry <= '0;
						i <= i + 1'b1;
						step <= ACCUM;
						if (last_outer) begin
							i <= '0;
							step <= FINISH;
							mm_done <= 1'b1;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// quotient and result words, low words of v are final after the last FOLD_TOP
	always_ff @(posedge clk) begin
		if (store && step == QUOTIENT)
			q <= mul_s;
		if (store && step == FOLD_CARRY && last_outer) begin
			for (int k = 0; k < `NUM_WORDS; k++)
				mm_result[k*`WORD_WIDTH +: `WORD_WIDTH] <= v[k];
		end
	end

endmodule

// File: mont_pkg.sv
/* Montgomery datapath types
   single arithmetic word and the CIOS step sequence */
`include "modexp_consts.svh"

package mont_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;

	typedef enum logic [2:0] {
		ACCUM,	// v += a[i] * b
		CARRY_TOP,	// spill carry into the two top words
		QUOTIENT,	// q = v[0] * n_prime0 mod 2^w
		REDUCE,	// v = (v + q * n) >> w
		FOLD_TOP,
		FOLD_CARRY,
		FINISH
	} mont_step_e;

endpackage

// File: mul_add.sv
/* word multiply-accumulate
   registers low and high words of x*y + z + last_c */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module mul_add import mont_pkg::*; (
	input  logic  clk,
	input  word_t x,
	input  word_t y,
	input  word_t z,
	input  word_t last_c,
	output word_t s,
	output word_t c
);

	logic [2*`WORD_WIDTH-1:0] prod;
	logic [2*`WORD_WIDTH-1:0] sum;	// max (2^w-1)^2 + 2(2^w-1), no overflow

	assign prod = {{`WORD_WIDTH{1'b0}}, x} * {{`WORD_WIDTH{1'b0}}, y};
	assign sum = prod + {{`WORD_WIDTH{1'b0}}, z} + {{`WORD_WIDTH{1'b0}}, last_c};

	always_ff @(posedge clk) begin
		s <= sum[`WORD_WIDTH-1:0];
		c <= sum[2*`WORD_WIDTH-1:`WORD_WIDTH];
	end

endmodule

// File: operand_load.sv
/* serial operand loader
   one word of m, e, n, r and t per cycle after start_input */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module operand_load import mont_pkg::*, exp_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     start_input,
	input  word_t    m_word,
	input  word_t    e_word,
	input  word_t    n_word,
	input  word_t    r_word,
	input  word_t    t_word,
	input  word_t    n_prime0,
	output operand_t m_val,
	output operand_t e_val,
	output operand_t n_val,
	output operand_t r_val,
	output operand_t t_val,
	output word_t    n_prime0_val,
	output logic     load_done
);

	logic loading;
	logic [`WORD_IDX_WIDTH-1:0] word_cnt;	// slot of the word on the inputs

	assign load_done = loading && (int'(word_cnt) == `NUM_WORDS - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			loading <= 1'b0;
			word_cnt <= '0;
		end else if (!loading) begin
			if (start_input) begin
				loading <= 1'b1;
				word_cnt <= '0;
			end
		end else begin
			word_cnt <= word_cnt + 1'b1;
			if (load_done)
				loading <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!loading && start_input)
			n_prime0_val <= n_prime0;	// sampled with the strobe itself
		if (loading) begin
			m_val[word_cnt*`WORD_WIDTH +: `WORD_WIDTH] <= m_word;
			e_val[word_cnt*`WORD_WIDTH +: `WORD_WIDTH] <= e_word;
			n_val[word_cnt*`WORD_WIDTH +: `WORD_WIDTH] <= n_word;
			r_val[word_cnt*`WORD_WIDTH +: `WORD_WIDTH] <= r_word;
			t_val[word_cnt*`WORD_WIDTH +: `WORD_WIDTH] <= t_word;
		end
	end

endmodule

// File: sim.f
+incdir+.
mont_pkg.sv
exp_pkg.sv
mul_add.sv
mont_mult.sv
operand_load.sv
exp_ctrl.sv
modexp.sv
tb_clock.sv
tb_monitor.sv
tb_modexp.sv

// File: tb_clock.sv
/* testbench clock and reset
   10 ns clock, reset held high over the first two rising edges */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;	// released just after the second edge
	end

	always #5 clk = ~clk;	// 10 ns period

endmodule

// File: tb_modexp.sv
/* modexp testbench top
   reads the pattern records, runs every test through the DUT and reports the outcome */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module tb_modexp;

	localparam int NUM_TESTS = 6;
	localparam int REC_WORDS = 6 * `NUM_WORDS + 1;	// m e n r t, n_prime0, expected
	localparam int N_PRIME_OFS = 5 * `NUM_WORDS;
	localparam int EXP_OFS = 5 * `NUM_WORDS + 1;
	localparam int PRODUCT_CYCLES = `NUM_WORDS * (4 * `NUM_WORDS + 8) + 2;
	localparam int TEST_CYCLES = (2 * `OPERAND_WIDTH + 2) * PRODUCT_CYCLES
		+ `OPERAND_WIDTH + 100;	// plus exponent scan, load, gaps and output
	localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES;
	localparam string PATTERN_FILE = "modexp_patterns.hex";

	logic clk;
	logic reset;
	logic start_input;
	logic start_compute;
	logic get_result;
	logic [`WORD_WIDTH-1:0] m_word;
	logic [`WORD_WIDTH-1:0] e_word;
	logic [`WORD_WIDTH-1:0] n_word;
	logic [`WORD_WIDTH-1:0] r_word;
	logic [`WORD_WIDTH-1:0] t_word;
	logic [`WORD_WIDTH-1:0] n_prime0;
	logic [`WORD_WIDTH-1:0] res_word;
	logic res_valid;
	logic done;
	logic [`OPERAND_WIDTH-1:0] expected;
	int tests_done;
	int tests_failed;
	int error_count;
	int setup_errors;
	int cycle_count;
	integer seed;
	logic [`WORD_WIDTH-1:0] patterns [0:NUM_TESTS*REC_WORDS-1];

	tb_clock u_clock (
		.clk  (clk),
		.reset(reset)
	);

	modexp u_dut (
		.clk          (clk),
		.reset        (reset),
		.start_input  (start_input),
		.start_compute(start_compute),
		.get_result   (get_result),
		.m_word       (m_word),
		.e_word       (e_word),
		.n_word       (n_word),
		.r_word       (r_word),
		.t_word       (t_word),
		.n_prime0     (n_prime0),
		.res_word     (res_word),
		.res_valid    (res_valid),
		.done         (done)
	);

	tb_monitor u_monitor (
		.clk         (clk),
		.reset       (reset),
		.get_result  (get_result),
		.done        (done),
		.res_valid   (res_valid),
		.res_word    (res_word),
		.expected    (expected),
		.tests_done  (tests_done),
		.tests_failed(tests_failed),
		.error_count (error_count)
	);

	// inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_gap();
		int gap;
		gap = int'($unsigned($random(seed)) % 8);
		repeat (gap) step_cycle();
	endtask

	task automatic read_patterns();
		int fd;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("[ERROR] cannot open %s", PATTERN_FILE);
			setup_errors++;
		end else begin
			$fclose(fd);
			$readmemh(PATTERN_FILE, patterns);
			for (int t = 0; t < NUM_TESTS; t++) begin
				if (patterns[t * REC_WORDS + 2 * `NUM_WORDS][0] !== 1'b1) begin
					$display("[ERROR] pattern record %0d has an even or missing modulus", t);
					setup_errors++;
				end
			end
		end
	endtask

	// n_prime0 goes with the strobe, the operand words follow lsw first
	task automatic load_operands(input int base);
		step_cycle();
		start_input = 1'b1;
		n_prime0 = patterns[base + N_PRIME_OFS];
		for (int w = 0; w < `NUM_WORDS; w++) begin
			step_cycle();
			start_input = 1'b0;
			n_prime0 = '0;
			m_word = patterns[base + w];
			e_word = patterns[base + `NUM_WORDS + w];
			n_word = patterns[base + 2 * `NUM_WORDS + w];
			r_word = patterns[base + 3 * `NUM_WORDS + w];
			t_word = patterns[base + 4 * `NUM_WORDS + w];
		end
		step_cycle();
		m_word = '0;
		e_word = '0;
		n_word = '0;
		r_word = '0;
		t_word = '0;
	endtask

	task automatic start_computation();
		step_cycle();
		start_compute = 1'b1;
		step_cycle();
		start_compute = 1'b0;
	endtask

	task automatic request_result();
		step_cycle();
		get_result = 1'b1;
		step_cycle();
		get_result = 1'b0;
	endtask

	task automatic await_done();
		@(negedge clk);
		while (done !== 1'b1)
			@(negedge clk);
	endtask

	task automatic sync_with_monitor(input int count);
		while (tests_done < count)
			@(posedge clk);
	endtask

	task automatic run_test(input int t);
		int base;
		base = t * REC_WORDS;
		for (int w = 0; w < `NUM_WORDS; w++)
			expected[w*`WORD_WIDTH +: `WORD_WIDTH] = patterns[base + EXP_OFS + w];
		idle_gap();
		load_operands(base);
		idle_gap();
		start_computation();
		await_done();
		idle_gap();
		request_result();
		sync_with_monitor(t + 1);
	endtask

	initial begin
		start_input = 1'b0;
		start_compute = 1'b0;
		get_result = 1'b0;
		m_word = '0;
		e_word = '0;
		n_word = '0;
		r_word = '0;
		t_word = '0;
		n_prime0 = '0;
		expected = '0;
		seed = 71;
		setup_errors = 0;
		read_patterns();
		wait (reset == 1'b0);
		if (setup_errors == 0) begin
			for (int t = 0; t < NUM_TESTS; t++)	// no reset between tests
				run_test(t);
		end
		repeat (2) step_cycle();	// idle cycles after the last window are checked too
		$display("tests run %0d of %0d, failed %0d, errors %0d, setup errors %0d",
			tests_done, NUM_TESTS, tests_failed, error_count, setup_errors);
		if (setup_errors == 0 && tests_done == NUM_TESTS && tests_failed == 0
			&& error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// guard sized for the longest possible exponent in every test
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("[ERROR] timeout waiting for done after %0d cycles", cycle_count);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: tb_monitor.sv
/* result checker
   follows each get_result window and compares res_word with the expected words */
`timescale 1ns/1ps
`include "modexp_consts.svh"

module tb_monitor (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      get_result,
	input  logic                      done,
	input  logic                      res_valid,
	input  logic [`WORD_WIDTH-1:0]    res_word,
	input  logic [`OPERAND_WIDTH-1:0] expected,
	output int                        tests_done,
	output int                        tests_failed,
	output int                        error_count
);

	int words_left;	// result words still due in the open window
	int word_idx;
	int test_errors;
	logic [`WORD_WIDTH-1:0] want;

	task automatic close_test();
		error_count += test_errors;
		if (test_errors == 0) begin
			$display("test %0d ok, result %h", tests_done + 1, expected);
		end else begin
			$display("test %0d failed with %0d errors", tests_done + 1, test_errors);
			tests_failed++;
		end
		tests_done++;
	endtask

	// sampled mid-cycle, away from the edges where DUT outputs and stimulus change
	always @(negedge clk) begin
		if (reset) begin
			tests_done = 0;
			tests_failed = 0;
			error_count = 0;
			words_left = 0;
			word_idx = 0;
			test_errors = 0;
		end else begin
			if (words_left > 0) begin
				want = expected[word_idx*`WORD_WIDTH +: `WORD_WIDTH];
				if (res_valid !== 1'b1) begin
					$display("[FAIL] %0t res_valid expected 1 got %b (test %0d word %0d)",
						$time, res_valid, tests_done + 1, word_idx);
					test_errors++;
				end
				// done drops once get_result has been taken
				if (done !== 1'b0) begin
					$display("[FAIL] %0t done expected 0 got %b (test %0d word %0d)",
						$time, done, tests_done + 1, word_idx);
					test_errors++;
				end
				if (res_word !== want) begin
					$display("[FAIL] %0t res_word expected %h got %h (test %0d word %0d)",
						$time, want, res_word, tests_done + 1, word_idx);
					test_errors++;
				end
				word_idx++;
				words_left--;
				if (words_left == 0)
					close_test();
			end else begin
				if (res_valid !== 1'b0) begin
					$display("[FAIL] %0t res_valid expected 0 got %b outside the result window",
						$time, res_valid);
					error_count++;
				end
				if (res_word !== '0) begin
					$display("[FAIL] %0t res_word expected %h got %h outside the result window",
						$time, {`WORD_WIDTH{1'b0}}, res_word);
					error_count++;
				end
				// strobe taken in COMPLETE, words follow from the next cycle
				if (get_result === 1'b1 && done === 1'b1) begin
					words_left = `NUM_WORDS;
					word_idx = 0;
					test_errors = 0;
				end
			end
		end
	end

endmodule
